/* src/readout_pkg.sv */
package readout_pkg;

    //////////////////////////////////////////////////////////////////////
    // Panel geometry
    //////////////////////////////////////////////////////////////////////

    // ROIC memory banks walked per detector line
    localparam int NUM_BANKS = 12;

    // One channel word from a bank
    localparam int PIXEL_W = 24;

    //////////////////////////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////////////////////////

    typedef logic [PIXEL_W-1:0]   pixel_t;
    // One-hot, bit n selects bank n
    typedef logic [NUM_BANKS-1:0] bank_sel_t;
    // Line count and image height
    typedef logic [11:0]          line_cnt_t;
    // Beat index inside one bank
    typedef logic [7:0]           beat_cnt_t;

    //////////////////////////////////////////////////////////////////////
    // State machines
    //////////////////////////////////////////////////////////////////////

    // Line sequencer
    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN
    } seq_state_t;

    // Frame timing
    typedef enum logic [1:0] {
        WAIT_FRAME,
        ACTIVE,
        CLOSING
    } frame_state_t;

endpackage

/* src/bank_req_if.sv */
interface bank_req_if;

    // High only in the cycle the read is issued
    logic                   req_valid;

    // Bank being read, same one-hot as data_read_req
    readout_pkg::bank_sel_t bank;

    // Tags that ride along with the read
    logic                   first_of_frame;
    logic                   last_of_line;

    // Sequencer side
    modport seq (
        output req_valid,
        output bank,
        output first_of_frame,
        output last_of_line
    );

    // Data mux side
    modport mux (
        input  req_valid,
        input  bank,
        input  first_of_frame,
        input  last_of_line
    );

endinterface

/* src/frame_timing.sv */
module frame_timing (
    input  logic                   eim_clk,
    input  logic                   eim_rst,
    input  logic                   read_index,
    input  logic                   line_start,
    input  readout_pkg::line_cnt_t image_height,
    input  logic                   line_done,
    output logic                   line_go,
    output logic                   frame_active,
    output logic                   frame_reset
);

    readout_pkg::frame_state_t state;
    readout_pkg::line_cnt_t    lines_done;
    logic                      read_index_q;
    logic                      index_rise;
    logic                      line_busy;
    logic                      accept_line;
    logic                      last_line;

    // Rising edge of read_index opens a frame
    assign index_rise = read_index && !read_index_q;

    // Line start only counts inside a frame and between lines
    assign accept_line = line_start && (state == readout_pkg::ACTIVE) && !line_busy;

    // Line now finishing is the final one of the frame
    assign last_line = (lines_done + 1'b1) == image_height;

    assign frame_active = (state == readout_pkg::ACTIVE);

    //////////////////////////////////////////////////////////////////////
    // Frame start detection
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge eim_clk or posedge eim_rst) begin
        if (eim_rst) begin
            read_index_q <= 1'b0;
            frame_reset  <= 1'b0;
        end else begin
            read_index_q <= read_index;
            // One pulse per rising edge, one cycle late
            frame_reset  <= index_rise;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Frame FSM and line counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge eim_clk or posedge eim_rst) begin
        if (eim_rst) begin
            state      <= readout_pkg::WAIT_FRAME;
            lines_done <= '0;
        end else begin
            case (state)
                readout_pkg::WAIT_FRAME: begin
                    if (index_rise) begin
                        state      <= readout_pkg::ACTIVE;
                        lines_done <= '0;
                    end
                end
                readout_pkg::ACTIVE: begin
                    if (line_done) begin
                        lines_done <= lines_done + 1'b1;
                        if (last_line) begin
                            state <= readout_pkg::CLOSING;
                        end
                    end
                end
                // Hold until read_index drops so the same edge cannot reopen
                readout_pkg::CLOSING: begin
                    if (!read_index) begin
                        state <= readout_pkg::WAIT_FRAME;
                    end
                end
                default: state <= readout_pkg::WAIT_FRAME;
            endcase
        end
    end

    // Line handshake with the sequencer
    always_ff @(posedge eim_clk or posedge eim_rst) begin
        if (eim_rst) begin
            line_go   <= 1'b0;
            line_busy <= 1'b0;
        end else begin
            line_go <= accept_line;
            if (accept_line) begin
                line_busy <= 1'b1;
            end else if (line_done) begin
                line_busy <= 1'b0;
            end
        end
    end

endmodule

/* src/line_sequencer.sv */
module line_sequencer #(
    parameter int BANK_BEATS = 8
) (
    input  logic                   eim_clk,
    input  logic                   eim_rst,
    input  logic                   line_go,
    input  logic                   frame_active,
    input  logic                   fifo_room,
    bank_req_if.seq                req,
    output readout_pkg::bank_sel_t data_read_req,
    output logic                   line_done
);

    readout_pkg::seq_state_t state;
    readout_pkg::bank_sel_t  bank_oh;
    readout_pkg::beat_cnt_t  beat;
    logic                    first_pending;
    logic                    want_read;
    logic                    issue;
    logic                    last_beat;
    logic                    last_of_line;

    //////////////////////////////////////////////////////////////////////
    // Request decision
    //////////////////////////////////////////////////////////////////////

    // Line_go starts the walk in the same cycle, no idle beat
    assign want_read = (state == readout_pkg::READ) ||
                       ((state == readout_pkg::IDLE) && line_go);

    // No room means hold position and stay quiet
    assign issue = want_read && fifo_room;

    assign last_beat    = (beat == readout_pkg::beat_cnt_t'(BANK_BEATS - 1));
    assign last_of_line = last_beat && bank_oh[readout_pkg::NUM_BANKS-1];

    // Request to the ROIC banks
    assign data_read_req = issue ? bank_oh : '0;

    // Same request with tags toward the data mux
    assign req.req_valid      = issue;
    assign req.bank           = bank_oh;
    assign req.first_of_frame = first_pending;
    assign req.last_of_line   = last_of_line;

    // Pulse right after the final request of the line
    assign line_done = (state == readout_pkg::DRAIN);

    //////////////////////////////////////////////////////////////////////
    // Bank and beat walk
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge eim_clk or posedge eim_rst) begin
        if (eim_rst) begin
            state   <= readout_pkg::IDLE;
            bank_oh <= readout_pkg::bank_sel_t'(1);
            beat    <= '0;
        end else begin
            case (state)
                readout_pkg::IDLE: begin
                    if (line_go) begin
                        state <= readout_pkg::READ;
                    end
                end
                readout_pkg::READ: begin
                    if (issue && last_of_line) begin
                        state <= readout_pkg::DRAIN;
                    end
                end
                readout_pkg::DRAIN: state <= readout_pkg::IDLE;
                default:            state <= readout_pkg::IDLE;
            endcase

            if (issue) begin
                if (last_beat) begin
                    beat <= '0;
                    // Rotate, bank 11 wraps back to bank 0 for the next line
                    bank_oh <= {bank_oh[readout_pkg::NUM_BANKS-2:0],
                                bank_oh[readout_pkg::NUM_BANKS-1]};
                end else begin
                    beat <= beat + 1'b1;
                end
            end
        end
    end

    // First request of a frame gets the frame tag
    always_ff @(posedge eim_clk or posedge eim_rst) begin
        if (eim_rst) begin
            first_pending <= 1'b1;
        end else if (!frame_active) begin
            first_pending <= 1'b1;
        end else if (issue) begin
            first_pending <= 1'b0;
        end
    end

endmodule

/* src/bank_data_mux.sv */
module bank_data_mux #(
    parameter int READ_LATENCY = 2
) (
    input  logic                eim_clk,
    input  logic                eim_rst,
    bank_req_if.mux             req,
    input  readout_pkg::pixel_t roic_read_data_a [readout_pkg::NUM_BANKS],
    input  readout_pkg::pixel_t roic_read_data_b [readout_pkg::NUM_BANKS],
    output logic                wr_en,
    output readout_pkg::pixel_t wr_data_a,
    output readout_pkg::pixel_t wr_data_b,
    output logic                wr_last,
    output logic                wr_first
);

    localparam int LAST = READ_LATENCY - 1;

    // Tag pipeline, one stage per cycle of bank latency
    logic                   pipe_valid [READ_LATENCY];
    readout_pkg::bank_sel_t pipe_bank  [READ_LATENCY];
    logic                   pipe_first [READ_LATENCY];
    logic                   pipe_last  [READ_LATENCY];

    readout_pkg::pixel_t    sel_a;
    readout_pkg::pixel_t    sel_b;

    //////////////////////////////////////////////////////////////////////
    // Request tag delay
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge eim_clk or posedge eim_rst) begin
        if (eim_rst) begin
            for (int i = 0; i < READ_LATENCY; i++) begin
                pipe_valid[i] <= 1'b0;
            end
        end else begin
            pipe_valid[0] <= req.req_valid;
            for (int i = 1; i < READ_LATENCY; i++) begin
                pipe_valid[i] <= pipe_valid[i-1];
            end
        end
    end

    // Tags only matter where the valid bit is set
    always_ff @(posedge eim_clk) begin
        pipe_bank[0]  <= req.bank;
        pipe_first[0] <= req.first_of_frame;
        pipe_last[0]  <= req.last_of_line;
        for (int i = 1; i < READ_LATENCY; i++) begin
            pipe_bank[i]  <= pipe_bank[i-1];
            pipe_first[i] <= pipe_first[i-1];
            pipe_last[i]  <= pipe_last[i-1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bank select and capture
    //////////////////////////////////////////////////////////////////////

    // One-hot AND-OR select, bank lines are valid at the pipe end
    always_comb begin
        sel_a = '0;
        sel_b = '0;
        for (int i = 0; i < readout_pkg::NUM_BANKS; i++) begin
            if (pipe_bank[LAST][i]) begin
                sel_a = sel_a | roic_read_data_a[i];
                sel_b = sel_b | roic_read_data_b[i];
            end
        end
    end

    // FIFO write one cycle after the data is sampled
    always_ff @(posedge eim_clk or posedge eim_rst) begin
        if (eim_rst) begin
            wr_en    <= 1'b0;
            wr_first <= 1'b0;
            wr_last  <= 1'b0;
        end else begin
            wr_en    <= pipe_valid[LAST];
            wr_first <= pipe_valid[LAST] && pipe_first[LAST];
            wr_last  <= pipe_valid[LAST] && pipe_last[LAST];
        end
    end

    always_ff @(posedge eim_clk) begin
        wr_data_a <= sel_a;
        wr_data_b <= sel_b;
    end

endmodule

/* src/line_fifo.sv */
module line_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                eim_clk,
    input  logic                eim_rst,
    input  logic                reserve,
    input  logic                wr_en,
    input  readout_pkg::pixel_t wr_data_a,
    input  readout_pkg::pixel_t wr_data_b,
    input  logic                wr_last,
    input  logic                wr_first,
    output logic                fifo_room,
    input  logic                out_ready,
    output logic                out_valid,
    output readout_pkg::pixel_t out_data_a,
    output readout_pkg::pixel_t out_data_b,
    output logic                out_last,
    output logic                out_first
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // Entry storage, word pair plus tags
    readout_pkg::pixel_t mem_a     [FIFO_DEPTH];
    readout_pkg::pixel_t mem_b     [FIFO_DEPTH];
    logic                mem_last  [FIFO_DEPTH];
    logic                mem_first [FIFO_DEPTH];

    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    stored;
    logic [CNT_W-1:0]    reserved;
    logic [CNT_W:0]      committed;
    logic                pop;

    // Room counts reads already in flight toward us
    assign committed = stored + reserved;
    assign fifo_room = committed < (CNT_W + 1)'(FIFO_DEPTH);

    // Show-ahead read side
    assign out_valid  = (stored != '0);
    assign pop        = out_valid && out_ready;
    assign out_data_a = mem_a[rd_ptr];
    assign out_data_b = mem_b[rd_ptr];
    assign out_last   = out_valid && mem_last[rd_ptr];
    assign out_first  = out_valid && mem_first[rd_ptr];

    always_ff @(posedge eim_clk) begin
        if (wr_en) begin
            mem_a[wr_ptr]     <= wr_data_a;
            mem_b[wr_ptr]     <= wr_data_b;
            mem_last[wr_ptr]  <= wr_last;
            mem_first[wr_ptr] <= wr_first;
        end
    end

    always_ff @(posedge eim_clk or posedge eim_rst) begin
        if (eim_rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            stored   <= '0;
            reserved <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   stored <= stored + 1'b1;
                2'b01:   stored <= stored - 1'b1;
                default: stored <= stored;
            endcase
            // Each write settles one earlier reservation
            case ({reserve, wr_en})
                2'b10:   reserved <= reserved + 1'b1;
                2'b01:   reserved <= reserved - 1'b1;
                default: reserved <= reserved;
            endcase
        end
    end

endmodule

/* src/readout_top.sv */
module readout_top #(
    parameter int BANK_BEATS   = 8,
    parameter int READ_LATENCY = 2,
    parameter int FIFO_DEPTH   = 8
) (
    input  logic                   eim_clk,
    input  logic                   eim_rst,
    input  logic                   read_index,
    input  logic                   line_start,
    input  readout_pkg::line_cnt_t image_height,
    input  readout_pkg::pixel_t    roic_read_data_a [readout_pkg::NUM_BANKS],
    input  readout_pkg::pixel_t    roic_read_data_b [readout_pkg::NUM_BANKS],
    output readout_pkg::bank_sel_t data_read_req,
    input  logic                   read_axis_tready,
    output logic                   read_axis_tvalid,
    output readout_pkg::pixel_t    read_axis_tdata_a,
    output readout_pkg::pixel_t    read_axis_tdata_b,
    output logic                   read_axis_tlast,
    output logic                   read_axis_tuser,
    output logic                   frame_reset,
    output logic                   frame_active
);

    logic                line_go;
    logic                line_done;
    logic                fifo_room;
    logic                wr_en;
    logic                wr_last;
    logic                wr_first;
    readout_pkg::pixel_t wr_data_a;
    readout_pkg::pixel_t wr_data_b;

    bank_req_if req_if ();

    //////////////////////////////////////////////////////////////////////
    // Control path
    //////////////////////////////////////////////////////////////////////

    frame_timing u_frame_timing (
        .eim_clk      (eim_clk),
        .eim_rst      (eim_rst),
        .read_index   (read_index),
        .line_start   (line_start),
        .image_height (image_height),
        .line_done    (line_done),
        .line_go      (line_go),
        .frame_active (frame_active),
        .frame_reset  (frame_reset)
    );

    line_sequencer #(.BANK_BEATS(BANK_BEATS)) u_line_sequencer (
        .eim_clk       (eim_clk),
        .eim_rst       (eim_rst),
        .line_go       (line_go),
        .frame_active  (frame_active),
        .fifo_room     (fifo_room),
        .req           (req_if.seq),
        .data_read_req (data_read_req),
        .line_done     (line_done)
    );

    // Data path, bank words into the line FIFO
    bank_data_mux #(.READ_LATENCY(READ_LATENCY)) u_bank_data_mux (
        .eim_clk (eim_clk), .eim_rst (eim_rst), .req (req_if.mux),
        .roic_read_data_a (roic_read_data_a), .roic_read_data_b (roic_read_data_b),
        .wr_en (wr_en), .wr_data_a (wr_data_a), .wr_data_b (wr_data_b),
        .wr_last (wr_last), .wr_first (wr_first)
    );

    // Every issued read books one FIFO slot
    line_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_line_fifo (
        .eim_clk (eim_clk), .eim_rst (eim_rst), .reserve (req_if.req_valid),
        .wr_en (wr_en), .wr_data_a (wr_data_a), .wr_data_b (wr_data_b),
        .wr_last (wr_last), .wr_first (wr_first), .fifo_room (fifo_room),
        .out_ready (read_axis_tready), .out_valid (read_axis_tvalid),
        .out_data_a (read_axis_tdata_a), .out_data_b (read_axis_tdata_b),
        .out_last (read_axis_tlast), .out_first (read_axis_tuser)
    );

endmodule

/* verification/readout_checks.svh */
`ifndef READOUT_CHECKS_SVH
`define READOUT_CHECKS_SVH

//////////////////////////////////////////////////////////////////////
// Random source for ready stalls
//////////////////////////////////////////////////////////////////////

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken
function automatic int take_bits(input int n);
    int value;
    value = 0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        value = (value << 1) | int'(lfsr_state[0]);
    end
    return value;
endfunction

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

// Pixel words on the output stream
task automatic check_pixel(input string name, input readout_pkg::pixel_t got,
                           input readout_pkg::pixel_t exp);
    check_total++;
    if (got !== exp) begin
        err_count++;
        $display("ERR %0d ns %s got %h expected %h", $time, name, got, exp);
    end
endtask

// Markers and frame strobes
task automatic check_bit(input string name, input logic got, input logic exp);
    check_total++;
    if (got !== exp) begin
        err_count++;
        $display("ERR %0d ns %s got %b expected %b", $time, name, got, exp);
    end
endtask

// Lines, reads and pulses counted per frame
task automatic check_count(input string name, input readout_pkg::line_cnt_t got,
                           input readout_pkg::line_cnt_t exp);
    check_total++;
    if (got !== exp) begin
        err_count++;
        $display("ERR %0d ns %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

`endif

/* verification/readout_tb.sv */
module readout_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BANK_BEATS     = 8;
    localparam int READ_LATENCY   = 2;
    localparam int FIFO_DEPTH     = 8;
    localparam int NUM_BANKS      = readout_pkg::NUM_BANKS;
    localparam int BEATS_PER_LINE = NUM_BANKS * BANK_BEATS;
    localparam int TIMEOUT_CYCLES = 20000;

    logic                   eim_clk;
    logic                   eim_rst;
    logic                   read_index;
    logic                   line_start;
    readout_pkg::line_cnt_t image_height;
    readout_pkg::pixel_t    roic_read_data_a [NUM_BANKS];
    readout_pkg::pixel_t    roic_read_data_b [NUM_BANKS];
    readout_pkg::bank_sel_t data_read_req;
    logic                   read_axis_tready;
    logic                   read_axis_tvalid;
    readout_pkg::pixel_t    read_axis_tdata_a;
    readout_pkg::pixel_t    read_axis_tdata_b;
    logic                   read_axis_tlast;
    logic                   read_axis_tuser;
    logic                   frame_reset;
    logic                   frame_active;

    // Run bookkeeping
    int                     err_count;
    int                     check_total;
    int                     test_count;
    logic                   timed_out;
    logic [31:0]            lfsr_state;

    // Bank model and scoreboard state
    readout_pkg::bank_sel_t req_hist [READ_LATENCY+1];
    int                     bank_count [NUM_BANKS];
    logic [15:0]            cur_base;
    int                     stall_pct;
    int                     exp_lines;
    int                     rx_beats;
    int                     rx_lines;
    int                     reset_pulses;

    `include "readout_checks.svh"

    readout_top #(
        .BANK_BEATS   (BANK_BEATS),
        .READ_LATENCY (READ_LATENCY),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) dut (
        .eim_clk           (eim_clk),
        .eim_rst           (eim_rst),
        .read_index        (read_index),
        .line_start        (line_start),
        .image_height      (image_height),
        .roic_read_data_a  (roic_read_data_a),
        .roic_read_data_b  (roic_read_data_b),
        .data_read_req     (data_read_req),
        .read_axis_tready  (read_axis_tready),
        .read_axis_tvalid  (read_axis_tvalid),
        .read_axis_tdata_a (read_axis_tdata_a),
        .read_axis_tdata_b (read_axis_tdata_b),
        .read_axis_tlast   (read_axis_tlast),
        .read_axis_tuser   (read_axis_tuser),
        .frame_reset       (frame_reset),
        .frame_active      (frame_active)
    );

    initial begin
        eim_clk = 1'b0;
        forever #10 eim_clk = ~eim_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Models and helpers
    //////////////////////////////////////////////////////////////////////

    // Channel a word from base, bank and running beat of that bank
    function automatic readout_pkg::pixel_t model_word(input logic [15:0] base,
                                                       input int bank, input int idx);
        logic [3:0] bank_f;
        logic [3:0] idx_f;
        bank_f = 4'(bank);
        idx_f  = 4'(idx);
        return {base, bank_f, idx_f};
    endfunction

    // Closing counts line and then the verdict
    task automatic end_run();
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_total, err_count);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        err_count++;
        timed_out = 1'b1;
        $display("Timed out at %0d ns while waiting for %s", $time, what);
    endtask

    // One output beat checked against the walk order
    task automatic record_beat();
        int                  line_idx;
        int                  bank_idx;
        int                  beat_idx;
        readout_pkg::pixel_t exp_a;
        line_idx = rx_beats / BEATS_PER_LINE;
        bank_idx = (rx_beats % BEATS_PER_LINE) / BANK_BEATS;
        beat_idx = rx_beats % BANK_BEATS;
        if (line_idx >= exp_lines) begin
            err_count++;
            $display("Extra output beat after the last line of the frame at %0d ns", $time);
        end else begin
            exp_a = model_word(cur_base, bank_idx, line_idx * BANK_BEATS + beat_idx);
            check_pixel("read_axis_tdata_a", read_axis_tdata_a, exp_a);
            check_pixel("read_axis_tdata_b", read_axis_tdata_b, ~exp_a);
            check_bit("read_axis_tlast", read_axis_tlast,
                      (bank_idx == NUM_BANKS - 1) && (beat_idx == BANK_BEATS - 1));
            check_bit("read_axis_tuser", read_axis_tuser, rx_beats == 0);
        end
        rx_beats++;
        if (read_axis_tlast) begin
            rx_lines++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bank memory, ready stalls and output monitor
    //////////////////////////////////////////////////////////////////////

    // Bank answers, ready and output sampling all happen mid-cycle
    always @(negedge eim_clk) begin
        for (int i = READ_LATENCY; i > 0; i--) begin
            req_hist[i] = req_hist[i-1];
        end
        req_hist[0] = data_read_req;
        // Answer READ_LATENCY cycles after the request
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (req_hist[READ_LATENCY][b]) begin
                roic_read_data_a[b] = model_word(cur_base, b, bank_count[b]);
                roic_read_data_b[b] = ~roic_read_data_a[b];
                bank_count[b]++;
            end
        end
        if (frame_reset) begin
            reset_pulses++;
        end
        // 7 bits scaled to 0..99
        if (stall_pct == 0) begin
            read_axis_tready = 1'b1;
        end else begin
            read_axis_tready = ((take_bits(7) * 100) >> 7) >= stall_pct;
        end
        // Transfer happens on the coming rising edge
        if (read_axis_tvalid && read_axis_tready) begin
            record_beat();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic pulse_line_start();
        line_start = 1'b1;
        @(negedge eim_clk);
        line_start = 1'b0;
    endtask

    task automatic wait_frame_open();
        int cycles;
        cycles = 0;
        while (!frame_active && cycles < TIMEOUT_CYCLES) begin
            @(negedge eim_clk);
            cycles++;
        end
        if (!frame_active) begin
            report_timeout("frame_active to rise");
        end
    endtask

    task automatic wait_beats(input int target);
        int cycles;
        cycles = 0;
        while (rx_beats < target && cycles < TIMEOUT_CYCLES) begin
            @(negedge eim_clk);
            cycles++;
        end
        if (rx_beats < target) begin
            report_timeout("the beats of a line");
        end
    endtask

    task automatic run_test(input int height, input int starts, input int pct,
                            input logic [15:0] base);
        int exp_l;
        int errs_before;
        int reads;
        errs_before = err_count;
        exp_l = (starts < height) ? starts : height;
        @(negedge eim_clk);
        cur_base     = base;
        stall_pct    = pct;
        exp_lines    = exp_l;
        image_height = readout_pkg::line_cnt_t'(height);
        rx_beats     = 0;
        rx_lines     = 0;
        reset_pulses = 0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_count[b] = 0;
        end

        // No frame yet, so this start is dropped
        pulse_line_start();
        repeat (4) begin
            @(negedge eim_clk);
            check_bit("data_read_req", |data_read_req, 1'b0);
        end

        read_index = 1'b1;
        wait_frame_open();
        if (timed_out) begin
            return;
        end
        for (int k = 0; k < starts; k++) begin
            pulse_line_start();
            if (k < height) begin
                // Second start lands while the line is running
                repeat (3) @(negedge eim_clk);
                pulse_line_start();
                wait_beats((k + 1) * BEATS_PER_LINE);
                if (timed_out) begin
                    return;
                end
            end else begin
                repeat (20) @(negedge eim_clk);
            end
        end

        // Let stray beats or reads show up
        repeat (40) @(negedge eim_clk);
        reads = 0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            reads += bank_count[b];
        end
        check_count("lines", readout_pkg::line_cnt_t'(rx_lines),
                    readout_pkg::line_cnt_t'(exp_l));
        check_count("bank reads", readout_pkg::line_cnt_t'(reads),
                    readout_pkg::line_cnt_t'(exp_l * BEATS_PER_LINE));
        check_count("frame_reset pulses", readout_pkg::line_cnt_t'(reset_pulses),
                    readout_pkg::line_cnt_t'(1));
        check_bit("frame_active", frame_active, 1'b0);
        read_index = 1'b0;
        repeat (2) @(negedge eim_clk);
        $display("Test %0d done: height %0d, starts %0d, stall %0d%%, beats %0d, errors %0d",
                 test_count, height, starts, pct, rx_beats, err_count - errs_before);
    endtask

    // Idle levels of every output
    task automatic check_idle_outputs();
        check_bit("read_axis_tvalid", read_axis_tvalid, 1'b0);
        check_bit("read_axis_tlast", read_axis_tlast, 1'b0);
        check_bit("read_axis_tuser", read_axis_tuser, 1'b0);
        check_bit("frame_reset", frame_reset, 1'b0);
        check_bit("frame_active", frame_active, 1'b0);
        check_bit("data_read_req", |data_read_req, 1'b0);
    endtask

    initial begin
        int          fd;
        int          code;
        int          height;
        int          starts;
        int          pct;
        logic [15:0] base;
        string       text;
        err_count        = 0;
        check_total      = 0;
        test_count       = 0;
        timed_out        = 1'b0;
        lfsr_state       = 32'h83a8f714;
        eim_rst          = 1'b1;
        read_index       = 1'b0;
        line_start       = 1'b0;
        image_height     = '0;
        read_axis_tready = 1'b0;
        cur_base         = '0;
        stall_pct        = 0;
        exp_lines        = 0;
        rx_beats         = 0;
        rx_lines         = 0;
        reset_pulses     = 0;
        for (int i = 0; i <= READ_LATENCY; i++) begin
            req_hist[i] = '0;
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            roic_read_data_a[b] = '0;
            roic_read_data_b[b] = '0;
            bank_count[b]       = 0;
        end

        repeat (4) @(posedge eim_clk);
        @(negedge eim_clk);
        check_idle_outputs();
        eim_rst = 1'b0;
        @(negedge eim_clk);
        check_idle_outputs();

        fd = $fopen("verification/readout_testdata.txt", "r");
        if (fd == 0) begin
            err_count++;
            $display("Could not open the test data file");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                code = $fgets(text, fd);
                // Header lines do not scan as four numbers
                if (code != 0 && $sscanf(text, "%d %d %d %h", height, starts, pct, base) == 4)
                begin
                    test_count++;
                    run_test(height, starts, pct, base);
                end
            end
            $fclose(fd);
            if (test_count == 0) begin
                err_count++;
                $display("No tests found in the test data file");
            end
        end
        end_run();
    end

endmodule

/* vlog.f */
+incdir+verification
src/readout_pkg.sv
src/bank_req_if.sv
src/frame_timing.sv
src/line_sequencer.sv
src/bank_data_mux.sv
src/line_fifo.sv
src/readout_top.sv
verification/readout_tb.sv

/* Bender.yml */
package:
  name: readout

sources:
  - files:
      - src/readout_pkg.sv
      - src/bank_req_if.sv
      - src/frame_timing.sv
      - src/line_sequencer.sv
      - src/bank_data_mux.sv
      - src/line_fifo.sv
      - src/readout_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/readout_tb.sv

/* verification/readout_testdata.txt */
# One test per line: image_height line_start_count ready_low_percent data_base
# First three columns decimal, data base 16-bit hex
1 1 0 1000
2 2 0 2a51
3 5 0 3c07
2 2 30 4e92
3 3 60 5b18
2 5 45 6f3d
4 4 80 7a64
1 3 20 8d2e
